// ==== common/icache_pkg.sv ====
// ==============================
// Instruction cache definitions
// ==============================
// Fixed geometry of a 4-way, 16-set cache with 128-bit lines
// Address split is tag | set | word offset | byte offset

package icache_pkg;

    // ==============================
    // Geometry
    // ==============================

    // Instruction word width
    localparam int XLEN      = 32;
    // One line holds four instruction words
    localparam int LINE_BITS = 128;
    // Associativity and number of sets
    localparam int N_WAYS    = 4;
    localparam int N_SETS    = 16;
    // Field widths of way number and address parts
    localparam int WAY_W     = 2;
    localparam int SET_W     = 4;
    localparam int OFS_W     = 2;
    localparam int BYTE_W    = 2;
    // Remaining upper address bits form the tag
    localparam int TAG_W     = XLEN - SET_W - OFS_W - BYTE_W;

    // ==============================
    // Vector types
    // ==============================

    typedef logic [XLEN-1:0]      addr_t;
    typedef logic [XLEN-1:0]      word_t;
    // Word 0 sits in the lowest 32 bits
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [SET_W-1:0]     set_t;
    typedef logic [OFS_W-1:0]     ofs_t;
    typedef logic [WAY_W-1:0]     way_t;

    // Controller FSM states
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } ctrl_state_e;

endpackage

// ==== common/lookup_if.sv ====
`timescale 1ns/100ps

// Decoded request fields and the tag match result
// All signals come from the decode stage
interface lookup_if;
    import icache_pkg::*;

    // Captured request address split into fields
    tag_t req_tag;
    set_t req_set;
    ofs_t req_ofs;
    // Tag compare outcome for the selected set
    logic hit;
    way_t hit_way;

    // Decode stage drives everything
    modport dec (output req_tag, req_set, req_ofs, hit, hit_way);
    // Controller needs the line address and the hit flag
    modport exe (input req_tag, req_set, hit);
    // Data arrays need the index, the word offset and the hit way
    modport res (input req_set, req_ofs, hit_way);

endinterface

// ==== hw/icache/tag_lookup.sv ====
`timescale 1ns/100ps

// Decode stage
// Holds the request address, the tag array and the valid bits,
// and reports which way of the indexed set matches
module tag_lookup (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              accept_i,
    input  icache_pkg::addr_t p_addr_i,
    input  logic              fill_we_i,
    input  icache_pkg::way_t  fill_way_i,
    lookup_if.dec             lk
);
    import icache_pkg::*;

    // Captured request fields, byte offset is not needed
    tag_t tag_q;
    set_t set_q;
    ofs_t ofs_q;

    // Per way tag storage and valid flags
    tag_t tag_mem [N_WAYS][N_SETS];
    logic valid_q [N_WAYS][N_SETS];

    // One match flag per way
    logic [N_WAYS-1:0] way_hit;

    // ==============================
    // Request capture
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (accept_i)
        begin
            tag_q <= p_addr_i[XLEN-1 -: TAG_W];
            set_q <= p_addr_i[BYTE_W+OFS_W +: SET_W];
            ofs_q <= p_addr_i[BYTE_W +: OFS_W];
        end
    end

    // Tag write on refill, into the victim way of the request set
    always_ff @(posedge clk_i)
    begin
        if (fill_we_i)
            tag_mem[fill_way_i][set_q] <= tag_q;
    end

    // Valid bits are flops so reset clears the whole cache at once
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int w = 0; w < N_WAYS; w++)
                for (int s = 0; s < N_SETS; s++)
                    valid_q[w][s] <= 1'b0;
        end
        else if (fill_we_i)
        begin
            valid_q[fill_way_i][set_q] <= 1'b1;
        end
    end

    // ==============================
    // Tag compare
    // ==============================
    always_comb
    begin
        lk.hit_way = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            way_hit[w] = valid_q[w][set_q] && (tag_mem[w][set_q] == tag_q);
            // At most one way matches, so OR encoding is enough
            if (way_hit[w])
                lk.hit_way = lk.hit_way | way_t'(w);
        end
    end

    assign lk.hit     = |way_hit;
    assign lk.req_tag = tag_q;
    assign lk.req_set = set_q;
    assign lk.req_ofs = ofs_q;

endmodule

// ==== hw/icache/refill_ctrl.sv ====
`timescale 1ns/100ps

// Execute stage
// Controller FSM, per set FIFO victim counters and the Wishbone refill master
module refill_ctrl (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              p_strobe_i,
    lookup_if.exe             lk,
    output logic              accept_o,
    output logic              resp_hit_o,
    output logic              fill_we_o,
    output icache_pkg::way_t  fill_way_o,
    // Wishbone classic master, read only
    output logic              m_cyc_o,
    output logic              m_stb_o,
    output icache_pkg::addr_t m_adr_o,
    input  logic              m_ack_i
);
    import icache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // Next victim way of each set
    way_t fifo_cnt [N_SETS];

    // Bus cycle flag and line address of the refill
    logic                     cyc_q;
    logic [TAG_W+SET_W-1:0]   line_adr_q;

    // ==============================
    // Controller FSM
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            IDLE:
                if (p_strobe_i)
                    state_d = LOOKUP;
            // Single cycle, lookup outputs are ready here
            LOOKUP:
                if (lk.hit)
                    state_d = IDLE;
                else
                    state_d = REFILL;
            // Wait for the memory to acknowledge the line
            REFILL:
                if (m_ack_i)
                    state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    // Strobe only counts in IDLE
    assign accept_o   = (state_q == IDLE) && p_strobe_i;
    assign resp_hit_o = (state_q == LOOKUP) && lk.hit;
    // Line arrives on the ack edge
    assign fill_we_o  = (state_q == REFILL) && m_ack_i;

    // ==============================
    // FIFO replacement
    // ==============================
    assign fill_way_o = fifo_cnt[lk.req_set];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                fifo_cnt[s] <= '0;
        end
        else if (fill_we_o)
        begin
            // Two bit counter wraps after way 3
            fifo_cnt[lk.req_set] <= way_t'(fifo_cnt[lk.req_set] + 1'b1);
        end
    end

    // ==============================
    // Wishbone refill master
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            cyc_q <= 1'b0;
        else if ((state_q == LOOKUP) && !lk.hit)
            cyc_q <= 1'b1;
        else if (fill_we_o)
            cyc_q <= 1'b0;
    end

    // Loaded once per miss and held until ack
    always_ff @(posedge clk_i)
    begin
        if ((state_q == LOOKUP) && !lk.hit)
            line_adr_q <= {lk.req_tag, lk.req_set};
    end

    // Classic single beat, strobe follows the cycle
    assign m_cyc_o = cyc_q;
    assign m_stb_o = cyc_q;
    // Word offset and byte bits always zero for a line address
    assign m_adr_o = {line_adr_q, {(OFS_W+BYTE_W){1'b0}}};

endmodule

// ==== hw/icache/data_store.sv ====
`timescale 1ns/100ps

// Result stage
// Line arrays per way, word select and the registered fetch response
module data_store (
    input  logic              clk_i,
    input  logic              rst_i,
    lookup_if.res             lk,
    input  logic              resp_hit_i,
    input  logic              fill_we_i,
    input  icache_pkg::way_t  fill_way_i,
    input  icache_pkg::line_t m_dat_i,
    output icache_pkg::word_t p_data_o,
    output logic              p_ready_o
);
    import icache_pkg::*;

    // One line per set in every way
    line_t line_mem [N_WAYS][N_SETS];

    // Line feeding the word mux and the chosen word
    line_t src_line;
    word_t sel_word;

    word_t data_q;
    logic  ready_q;

    // ==============================
    // Line storage
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (fill_we_i)
            line_mem[fill_way_i][lk.req_set] <= m_dat_i;
    end

    // ==============================
    // Word select
    // ==============================
    // On refill the word comes straight from the bus line
    assign src_line = fill_we_i ? m_dat_i : line_mem[lk.hit_way][lk.req_set];

    always_comb
    begin
        sel_word = '0;
        for (int i = 0; i < 2**OFS_W; i++)
        begin
            // Word 0 in the lowest bits
            if (lk.req_ofs == ofs_t'(i))
                sel_word = src_line[i*XLEN +: XLEN];
        end
    end

    // ==============================
    // Response register
    // ==============================
    always_ff @(posedge clk_i)
    begin
        if (resp_hit_i || fill_we_i)
            data_q <= sel_word;
    end

    // One cycle ready pulse after either source
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            ready_q <= 1'b0;
        else
            ready_q <= resp_hit_i || fill_we_i;
    end

    assign p_data_o  = data_q;
    assign p_ready_o = ready_q;

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/100ps

// Read-only L1 instruction cache
// Decode stage finds the hit way, execute stage runs the FSM and the refill,
// result stage holds the lines and returns the word
module icache_top (
    input  logic                clk_i,
    input  logic                rst_i,
    // Processor fetch port
    input  logic                p_strobe_i,
    input  icache_pkg::addr_t   p_addr_i,
    output icache_pkg::word_t   p_data_o,
    output logic                p_ready_o,
    // Wishbone classic refill master
    output logic                m_cyc_o,
    output logic                m_stb_o,
    output icache_pkg::addr_t   m_adr_o,
    input  icache_pkg::line_t   m_dat_i,
    input  logic                m_ack_i
);
    import icache_pkg::*;

    // Stage to stage controls
    logic accept;
    logic resp_hit;
    logic fill_we;
    way_t fill_way;

    // Decoded request shared by all stages
    lookup_if u_lk ();

    // ==============================
    // Decode stage
    // ==============================
    tag_lookup u_tag_lookup (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .accept_i   (accept),
        .p_addr_i   (p_addr_i),
        .fill_we_i  (fill_we),
        .fill_way_i (fill_way),
        .lk         (u_lk.dec)
    );

    // ==============================
    // Execute stage
    // ==============================
    refill_ctrl u_refill_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .p_strobe_i (p_strobe_i),
        .lk         (u_lk.exe),
        .accept_o   (accept),
        .resp_hit_o (resp_hit),
        .fill_we_o  (fill_we),
        .fill_way_o (fill_way),
        .m_cyc_o    (m_cyc_o),
        .m_stb_o    (m_stb_o),
        .m_adr_o    (m_adr_o),
        .m_ack_i    (m_ack_i)
    );

    // ==============================
    // Result stage
    // ==============================
    data_store u_data_store (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .lk         (u_lk.res),
        .resp_hit_i (resp_hit),
        .fill_we_i  (fill_we),
        .fill_way_i (fill_way),
        .m_dat_i    (m_dat_i),
        .p_data_o   (p_data_o),
        .p_ready_o  (p_ready_o)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

// Free running testbench clock, 40 ns period
module tb_clock_gen (
    output logic clk_o
);
    // Half of the 40 ns period
    localparam int HALF_PERIOD = 20;

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #HALF_PERIOD;
            clk_o = ~clk_o;
        end
    end

endmodule

// ==== testbench/icache_asserts.sv ====
`timescale 1ns/100ps

// Protocol checks on the fetch port and the Wishbone refill port
module icache_asserts (
    input logic              clk_i,
    input logic              rst_i,
    input logic              p_strobe_i,
    input logic              p_ready_o,
    input logic              m_cyc_o,
    input logic              m_stb_o,
    input icache_pkg::addr_t m_adr_o,
    input logic              m_ack_i
);
    // Number of failed properties for the testbench to watch
    int fail_cnt = 0;

    // ==============================
    // Wishbone classic
    // ==============================
    // Strobe tracks the cycle of a single beat master
    stb_follows_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        m_stb_o == m_cyc_o)
        else
        begin
            $error("m_stb_o differs from m_cyc_o");
            fail_cnt++;
        end

    // Address held while the slave stalls
    adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (m_stb_o && !m_ack_i) |=> $stable(m_adr_o))
        else
        begin
            $error("m_adr_o changed before ack");
            fail_cnt++;
        end

    // Line aligned refill address
    adr_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        m_cyc_o |-> (m_adr_o[3:0] == 4'h0))
        else
        begin
            $error("m_adr_o is not line aligned");
            fail_cnt++;
        end

    // Cycle ends on the ack edge
    cyc_ends_on_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        (m_cyc_o && m_ack_i) |=> !m_cyc_o)
        else
        begin
            $error("m_cyc_o still high after ack");
            fail_cnt++;
        end

    // ==============================
    // Fetch port
    // ==============================
    ready_is_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_o |=> !p_ready_o)
        else
        begin
            $error("p_ready_o high for two cycles");
            fail_cnt++;
        end

    // Two cycles after a strobe either the hit answer or the refill is seen
    hit_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        p_strobe_i |-> ##2 (p_ready_o != m_cyc_o))
        else
        begin
            $error("hit response not exactly 2 cycles after strobe");
            fail_cnt++;
        end

endmodule

bind icache_top icache_asserts u_icache_asserts (.*);

// ==== testbench/tb_icache.sv ====
`timescale 1ns/100ps

// Testbench for the instruction cache
// Cases come from a file and the memory answers after random wait cycles
module tb_icache;
    import icache_pkg::*;

    // Inputs change this long after the rising edge
    localparam int DRIVE_DLY = 2;
    localparam int RST_CYCLES = 10;
    localparam logic [31:0] LFSR_SEED = 32'd98338;

    logic  clk;
    logic  rst;
    logic  p_strobe;
    addr_t p_addr;
    word_t p_data;
    logic  p_ready;
    logic  m_cyc;
    logic  m_stb;
    addr_t m_adr;
    line_t m_dat;
    logic  m_ack;

    // Case table
    string       case_name[$];
    logic [31:0] case_addr[$];
    logic [31:0] case_word[$];
    logic [31:0] case_miss[$];

    logic [31:0] lfsr_q;
    int          bus_cycles;
    int          cycle_cnt;
    int          cycle_limit;

    tb_clock_gen u_clk_gen (
        .clk_o (clk)
    );

    icache_top u_icache_top (
        .clk_i      (clk),
        .rst_i      (rst),
        .p_strobe_i (p_strobe),
        .p_addr_i   (p_addr),
        .p_data_o   (p_data),
        .p_ready_o  (p_ready),
        .m_cyc_o    (m_cyc),
        .m_stb_o    (m_stb),
        .m_adr_o    (m_adr),
        .m_dat_i    (m_dat),
        .m_ack_i    (m_ack)
    );

    // ==============================
    // Helpers
    // ==============================
    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[6:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("error %s %s: expected %h, actual %h", test, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "mismatch in %s", test);
        end
    endtask

    // Read name, address, word and miss flag per line
    task automatic read_cases();
        int    fd;
        int    n;
        string line;
        string name;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] m;
        fd = $fopen("testbench/icache_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the case file testbench/icache_cases.txt");
            $display("Test failures found");
            $fatal(1, "no case file");
        end
        while ($fgets(line, fd) != 0)
        begin
            // Skip comment lines
            if (line.len() > 0 && line[0] != "#")
            begin
                n = $sscanf(line, "%s %h %h %h", name, a, w, m);
                if (n == 4)
                begin
                    case_name.push_back(name);
                    case_addr.push_back(a);
                    case_word.push_back(w);
                    case_miss.push_back(m);
                end
            end
        end
        $fclose(fd);
    endtask

    // Strobe one address and wait for the response while counting edges of latency
    task automatic fetch(input addr_t addr, output word_t data, output int lat);
        bus_cycles = 0;
        @(posedge clk);
        #DRIVE_DLY;
        p_strobe = 1'b1;
        p_addr   = addr;
        @(posedge clk);
        #DRIVE_DLY;
        p_strobe = 1'b0;
        lat = 1;
        while (!p_ready)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            lat++;
        end
        data = p_data;
    endtask

    // ==============================
    // Memory model
    // ==============================
    initial
    begin : mem_model
        logic [7:0] wait_cycles;
        m_ack = 1'b0;
        m_dat = '0;
        forever
        begin
            @(posedge clk);
            #DRIVE_DLY;
            if (m_cyc && m_stb && !m_ack)
            begin
                // 0 to 7 wait cycles
                take_bits(3, wait_cycles);
                repeat (wait_cycles)
                    @(posedge clk);
                #DRIVE_DLY;
                for (int i = 0; i < 4; i++)
                    m_dat[i*32 +: 32] = (m_adr + 32'(4 * i)) ^ 32'h5A5A_0000;
                m_ack = 1'b1;
                bus_cycles++;
                @(posedge clk);
                #DRIVE_DLY;
                m_ack = 1'b0;
                m_dat = '0;
            end
        end
    end

    // Timeout limit scales with the number of cases
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Run timed out after %0d cycles before all cases finished", cycle_cnt);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    // Bound protocol assertions count their failures
    always @(posedge clk)
    begin
        if (u_icache_top.u_icache_asserts.fail_cnt != 0)
        begin
            $display("A bound protocol assertion failed");
            $display("Test failures found");
            $fatal(1, "assertion failure");
        end
    end

    // ==============================
    // Main sequence
    // ==============================
    initial
    begin : main_seq
        word_t data;
        int    lat;
        lfsr_q      = LFSR_SEED;
        cycle_cnt   = 0;
        cycle_limit = 100000;
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_addr   = '0;
        read_cases();
        cycle_limit = 100 + 20 * case_name.size();

        repeat (RST_CYCLES)
            @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // Idle outputs after reset
        check_value("reset", "p_ready_o", 32'(1'b0), 32'(p_ready));
        check_value("reset", "m_cyc_o", 32'(1'b0), 32'(m_cyc));
        check_value("reset", "m_stb_o", 32'(1'b0), 32'(m_stb));

        for (int i = 0; i < case_name.size(); i++)
        begin
            fetch(case_addr[i], data, lat);
            check_value(case_name[i], "word", case_word[i], data);
            // Miss means exactly one bus cycle
            check_value(case_name[i], "miss", case_miss[i], 32'(bus_cycles));
            if (case_miss[i] == 0)
                check_value(case_name[i], "latency", 32'd2, 32'(lat));
        end

        if (u_icache_top.u_icache_asserts.fail_cnt == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            $display("A bound protocol assertion failed");
            $display("Test failures found");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// ==== icache.f ====
common/icache_pkg.sv
common/lookup_if.sv
hw/icache/tag_lookup.sv
hw/icache/refill_ctrl.sv
hw/icache/data_store.sv
hw/icache_top.sv
testbench/tb_clock_gen.sv
testbench/icache_asserts.sv
testbench/tb_icache.sv

// ==== testbench/icache_cases.txt ====
# name address expected_word expected_miss
# hex address and word, miss is 1 when one Wishbone cycle is expected
first_miss 00001000 5A5A1000 1
repeat_hit 00001000 5A5A1000 0
ofs1_hit 00001004 5A5A1004 0
ofs2_hit 00001008 5A5A1008 0
ofs3_hit 0000100C 5A5A100C 0
refill_ofs2 00002028 5A5A2028 1
hit_ofs0 00002020 5A5A2020 0
hit_ofs1 00002024 5A5A2024 0
hit_ofs3 0000202C 5A5A202C 0
fifo_tag1 00000150 5A5A0150 1
fifo_tag2 00000254 5A5A0254 1
fifo_tag3 00000358 5A5A0358 1
fifo_tag4 0000045C 5A5A045C 1
fifo_tag5 00000550 5A5A0550 1
evicted_tag1 00000150 5A5A0150 1
kept_tag3 00000354 5A5A0354 0
kept_tag4 00000458 5A5A0458 0
kept_tag5 0000055C 5A5A055C 0
high_miss ABCD0070 F1970070 1
high_hit ABCD0074 F1970074 0
line_again 0000100C 5A5A100C 0
